/* logic/mem_bus_pkg.sv */
// Memory bus definitions
package mem_bus_pkg;

    // Byte address width.
    localparam int ADDR_W = 32;
    // Data width of the bus and the RAMs.
    localparam int DATA_W = 32;
    // One write enable per byte lane.
    localparam int WE_W = DATA_W / 8;

    // CPU ports sharing the bus.
    localparam int N_CPUS = 2;
    // Memory regions behind the mux.
    localparam int N_MEMS = 2;

    // Words per RAM.
    localparam int RAM_WORDS = 256;
    // Word index width inside one RAM.
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // Region base byte addresses, naturally aligned.
    localparam logic [ADDR_W-1:0] MEM_BASE [N_MEMS] = '{
        32'h0000_0000,
        32'h0001_0000
    };

    // Region sizes as log2 of bytes.
    // 1 KiB each, matches RAM_WORDS words.
    localparam int MEM_SIZE_LOG2 [N_MEMS] = '{10, 10};

    // One bus request, CPU to memory.
    // Active when re or any we bit is set.
    typedef struct packed {
        // Read enable.
        logic              re;
        // Byte write enables.
        logic [WE_W-1:0]   we;
        // Word address.
        logic [ADDR_W-1:2] addr;
        // Write data.
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // One bus response, memory to CPU.
    typedef struct packed {
        // Access complete.
        logic              ready;
        // Read data, valid with ready.
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

/* logic/mem_arbiter_rr.sv */
// Round-robin arbiter
module mem_arbiter_rr import mem_bus_pkg::*; (
    // Clock for the checks.
    input  logic              clk,
    // Synchronous reset.
    input  logic              rst,
    // Request per port.
    input  logic [N_CPUS-1:0] req,
    // Current holder, one-hot.
    input  logic [N_CPUS-1:0] cur,
    // Chosen port, one-hot or zero.
    output logic [N_CPUS-1:0] next
);

    // Priority token chain over two laps of the ports.
    // Bit i carries the token into port i mod N_CPUS.
    logic [2*N_CPUS-1:0] chain;

    // Nothing enters ahead of the first port.
    assign chain[0] = 1'b0;

    // The token starts right after the holder.
    // It passes every port that does not request.
    for (genvar i = 1; i < 2*N_CPUS; i++) begin : g_chain
        assign chain[i] = cur[(i-1) % N_CPUS]
                        | (chain[i-1] & ~req[(i-1) % N_CPUS]);
    end

    // A requester that holds the token in either lap wins.
    // The holder itself is reached last, in the second lap.
    for (genvar i = 0; i < N_CPUS; i++) begin : g_next
        assign next[i] = req[i] & (chain[i] | chain[i+N_CPUS]);
    end

    // Only one winner, and only among the requesters.
    a_next_valid: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(next) && ((next & ~req) == '0)
    ) else $error("Arbiter chose an invalid port.");

    // Someone requesting always gets a winner.
    a_next_live: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(cur) && (req != '0) |-> (next != '0)
    ) else $error("Arbiter dropped all requests.");

endmodule

/* logic/mem_demux.sv */
// CPU port arbitrating demultiplexer
module mem_demux import mem_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // CPU side.
    input  mem_req_t cpu_req [N_CPUS],
    output mem_rsp_t cpu_rsp [N_CPUS],
    // Shared bus side.
    output mem_req_t bus_req,
    input  mem_rsp_t bus_rsp
);

    // Port is asking for an access.
    logic [N_CPUS-1:0] req;
    // Custody register, one-hot.
    logic [N_CPUS-1:0] cur;
    // Round-robin choice among requesters.
    logic [N_CPUS-1:0] next;
    // Port forwarded this cycle.
    logic [N_CPUS-1:0] grant;
    // Shared bus carries an access.
    logic              bus_act;

    for (genvar g = 0; g < N_CPUS; g++) begin : g_port
        assign req[g] = cpu_req[g].re | (|cpu_req[g].we);
        // Ready only reaches the port holding custody.
        assign cpu_rsp[g] = '{
            ready: cur[g] & bus_rsp.ready,
            rdata: bus_rsp.rdata
        };
    end

    mem_arbiter_rr i_arbiter (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .cur  (cur),
        .next (next)
    );

    // Holder keeps the bus while it still requests.
    assign grant = (|(cur & req)) ? cur : next;

    // Custody follows the grant and stays put when idle.
    always_ff @(posedge clk) begin
        if (rst) begin
            cur <= N_CPUS'(1);
        end else if (|grant) begin
            cur <= grant;
        end
    end

    // Only the granted port reaches the bus.
    always_comb begin
        bus_req = '0;
        for (int i = 0; i < N_CPUS; i++) begin
            if (grant[i]) begin
                bus_req = mem_req_t'(bus_req | cpu_req[i]);
            end
        end
    end

    assign bus_act = bus_req.re | (|bus_req.we);

    // An access on the bus belongs to exactly one port.
    a_bus_owner: assert property (
        @(posedge clk) disable iff (rst)
        bus_act |-> $onehot(grant)
    ) else $error("Bus access without a single owner.");

endmodule

/* logic/mem_mux.sv */
// Address decoding memory multiplexer
module mem_mux import mem_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // Shared bus side.
    input  mem_req_t bus_req,
    output mem_rsp_t bus_rsp,
    // Memory side, one port per region.
    output mem_req_t ram_req [N_MEMS],
    input  mem_rsp_t ram_rsp [N_MEMS]
);

    // Bus carries an access this cycle.
    logic              bus_act;
    // Byte address of the access.
    logic [ADDR_W-1:0] byte_addr;
    // Region hit this cycle.
    logic [N_MEMS-1:0] sel;
    // Region hit last cycle.
    logic [N_MEMS-1:0] r_sel;
    // Access present last cycle.
    logic              r_act;

    assign bus_act   = bus_req.re | (|bus_req.we);
    assign byte_addr = {bus_req.addr, 2'b00};

    for (genvar g = 0; g < N_MEMS; g++) begin : g_region
        // Bits above the region size must match the base.
        localparam logic [ADDR_W-1:0] HI_MASK =
            ~((ADDR_W'(1) << MEM_SIZE_LOG2[g]) - ADDR_W'(1));

        assign sel[g] = bus_act
                      & ((byte_addr & HI_MASK) == (MEM_BASE[g] & HI_MASK));

        // Address and data go everywhere, strobes only to the hit.
        assign ram_req[g] = '{
            re:    bus_req.re & sel[g],
            we:    bus_req.we & {WE_W{sel[g]}},
            addr:  bus_req.addr,
            wdata: bus_req.wdata
        };
    end

    // Response belongs to the previous cycle's access.
    always_ff @(posedge clk) begin
        if (rst) begin
            r_sel <= '0;
            r_act <= 1'b0;
        end else begin
            r_sel <= sel;
            r_act <= bus_act;
        end
    end

    always_comb begin
        logic hit_ready;
        hit_ready     = 1'b0;
        bus_rsp.rdata = '0;
        for (int i = 0; i < N_MEMS; i++) begin
            if (r_sel[i]) begin
                hit_ready     = hit_ready | ram_rsp[i].ready;
                bus_rsp.rdata = bus_rsp.rdata | ram_rsp[i].rdata;
            end
        end
        // Unmapped access completes at once with zero data.
        bus_rsp.ready = r_act & ((r_sel == '0) | hit_ready);
    end

    // Regions never overlap.
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(sel)
    ) else $error("Address decodes to more than one region.");

endmodule

/* logic/mem_ram.sv */
// Byte-enabled word memory
module mem_ram import mem_bus_pkg::*; (
    input  logic     clk,
    // Request from the mux.
    input  mem_req_t req,
    // Response, data one cycle after re.
    output mem_rsp_t rsp
);

    // Storage, no reset.
    logic [DATA_W-1:0] mem [RAM_WORDS];
    // Read data register.
    logic [DATA_W-1:0] rdata_q;
    // Word index within this RAM.
    logic [RAM_AW-1:0] idx;

    // Low word-address bits select the word.
    // Upper bits were already decoded by the mux.
    assign idx = req.addr[RAM_AW+1:2];

    // Write only the enabled byte lanes.
    always_ff @(posedge clk) begin
        for (int b = 0; b < WE_W; b++) begin
            if (req.we[b]) begin
                mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    // Registered read.
    // Old contents on a same-cycle write.
    always_ff @(posedge clk) begin
        if (req.re) begin
            rdata_q <= mem[idx];
        end
    end

    // No wait states.
    assign rsp = '{
        ready: 1'b1,
        rdata: rdata_q
    };

endmodule

/* logic/mem_subsys_top.sv */
// Dual CPU memory subsystem
module mem_subsys_top import mem_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // CPU ports.
    input  mem_req_t cpu_req [N_CPUS],
    output mem_rsp_t cpu_rsp [N_CPUS]
);

    // Shared bus between demux and mux.
    mem_req_t bus_req;
    mem_rsp_t bus_rsp;
    // One link per memory region.
    mem_req_t ram_req [N_MEMS];
    mem_rsp_t ram_rsp [N_MEMS];

    mem_demux i_demux (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    mem_mux i_mux (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

    // One RAM behind each region.
    for (genvar g = 0; g < N_MEMS; g++) begin : g_ram
        mem_ram i_ram (
            .clk (clk),
            .req (ram_req[g]),
            .rsp (ram_rsp[g])
        );
    end

endmodule

/* verif/mem_checker.sv */
// Memory subsystem checker
module mem_checker import mem_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // DUT ports under watch.
    input  mem_req_t cpu_req [N_CPUS],
    input  mem_rsp_t cpu_rsp [N_CPUS],
    // Totals over the whole run.
    output int       total_checks,
    output int       total_errors
);

    timeunit 1ns;
    timeprecision 1ps;

    // Pending cycles before an access counts as lost.
    localparam int STALL_LIMIT = 32;

    // Shadow of both RAMs.
    logic [DATA_W-1:0] shadow [N_MEMS][RAM_WORDS];
    string test_name = "none";
    int    test_checks = 0;
    int    test_errors = 0;
    // Cycles spent pending, per port.
    int    stall [N_CPUS] = '{default: 0};
    // Accesses of other ports completed while this one waited.
    int    others [N_CPUS] = '{default: 0};

    initial begin
        total_checks = 0;
        total_errors = 0;
    end

    function automatic logic active(input mem_req_t req);
        return req.re | (|req.we);
    endfunction

    // Region holding a word address, or -1 when unmapped.
    function automatic int region_of(input logic [ADDR_W-1:2] addr);
        logic [ADDR_W-1:0] byte_addr;
        byte_addr = {addr, 2'b00};
        for (int r = 0; r < N_MEMS; r++) begin
            if ((byte_addr >> MEM_SIZE_LOG2[r]) == (MEM_BASE[r] >> MEM_SIZE_LOG2[r])) begin
                return r;
            end
        end
        return -1;
    endfunction

    // Reference read data.
    // Zero outside the memory map.
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:2] addr);
        int r;
        r = region_of(addr);
        if (r < 0) begin
            return '0;
        end
        return shadow[r][addr % RAM_WORDS];
    endfunction

    // Merge the enabled bytes into the shadow.
    task automatic shadow_write(input mem_req_t req);
        int r;
        r = region_of(req.addr);
        if (r >= 0) begin
            for (int b = 0; b < WE_W; b++) begin
                if (req.we[b]) begin
                    shadow[r][req.addr % RAM_WORDS][8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
        end
    endtask

    task automatic count_error();
        test_errors++;
        total_errors++;
    endtask

    // One completed access on port p.
    task automatic complete(input int p);
        logic [DATA_W-1:0] expected;
        test_checks++;
        total_checks++;
        if (others[p] > 1) begin
            $display("Error in %s: port %0d waited for %0d accesses of another port",
                     test_name, p, others[p]);
            count_error();
        end
        // Read sees the old word on a combined write.
        if (cpu_req[p].re) begin
            expected = expected_word(cpu_req[p].addr);
            if (cpu_rsp[p].rdata !== expected) begin
                $display("Fail %s expected %08h actual %08h at %08h",
                         test_name, expected, cpu_rsp[p].rdata, {cpu_req[p].addr, 2'b00});
                count_error();
            end
        end
        if (cpu_req[p].we != '0) begin
            shadow_write(cpu_req[p]);
        end
        for (int q = 0; q < N_CPUS; q++) begin
            if (q != p && active(cpu_req[q])) begin
                others[q]++;
            end
        end
        others[p] = 0;
        stall[p]  = 0;
    endtask

    task automatic pending(input int p);
        stall[p]++;
        if (stall[p] == STALL_LIMIT) begin
            $display("Error in %s: port %0d never completed its access", test_name, p);
            count_error();
        end
    endtask

    task start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task end_test();
        $display("Test %s %s: %0d checks, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
    endtask

    // Requests and responses are stable at the falling edge.
    // Active with ready means the access ends at the next rising edge.
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < N_CPUS; p++) begin
                if (active(cpu_req[p]) && cpu_rsp[p].ready) begin
                    complete(p);
                end else if (active(cpu_req[p])) begin
                    pending(p);
                end
            end
        end
    end

endmodule

/* verif/tb_mem_subsys.sv */
// Memory subsystem testbench
module tb_mem_subsys import mem_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Clock period in ns.
    localparam int CLK_PERIOD = 40;
    // Accesses in the random phase, both CPUs together.
    localparam int N_RANDOM = 200;
    // Accesses over all tests, sizes the watchdog.
    localparam int N_ACCESSES = 8 + 10 + 4 + 4 + N_RANDOM;
    // Words per region used by random traffic.
    localparam int POOL = 16;
    // Lies outside both regions.
    localparam logic [ADDR_W-1:0] UNMAPPED_BASE = 32'h0002_0000;

    logic     clk;
    logic     rst;
    mem_req_t cpu_req [N_CPUS];
    mem_rsp_t cpu_rsp [N_CPUS];
    int       total_checks;
    int       total_errors;
    int       seed;
    // Pool words that already hold a full write.
    bit [POOL-1:0] written [N_MEMS];

    mem_subsys_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    mem_checker i_chk (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .total_checks (total_checks),
        .total_errors (total_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog.
    // Eight cycles per access is far beyond the worst contention.
    initial begin
        #((N_ACCESSES * 8 + 100) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Word address of slot k in a region.
    // Region N_MEMS means unmapped space.
    function automatic logic [ADDR_W-1:2] word_at(input int region, input int k);
        logic [ADDR_W-1:0] base;
        base = (region < N_MEMS) ? MEM_BASE[region] : UNMAPPED_BASE;
        return base[ADDR_W-1:2] + (ADDR_W-2)'(k);
    endfunction

    // One access on port p.
    // Held until ready, then one idle cycle follows.
    task automatic cpu_access(input int p, input logic rd, input logic [WE_W-1:0] be,
                              input logic [ADDR_W-1:2] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        cpu_req[p] <= '{re: rd, we: be, addr: addr, wdata: data};
        do begin
            @(negedge clk);
        end while (!cpu_rsp[p].ready);
        @(posedge clk);
        cpu_req[p] <= '0;
    endtask

    // Mixed reads and writes over both regions and unmapped space.
    task automatic random_traffic(input int p, input int n);
        int                region;
        int                k;
        logic              rd;
        logic [WE_W-1:0]   be;
        logic [DATA_W-1:0] data;
        for (int i = 0; i < n; i++) begin
            // Slots 3 and 4 fold back, so unmapped gets one in five.
            region = {$random(seed)} % 5;
            if (region > N_MEMS) begin
                region = region - 3;
            end
            k    = {$random(seed)} % POOL;
            rd   = $random(seed);
            be   = $random(seed);
            data = $random(seed);
            if (be == '0) begin
                be = '1;
            end
            // A word is read only once it holds known data.
            if (region < N_MEMS && !written[region][k]) begin
                rd = 1'b0;
                be = '1;
            end
            cpu_access(p, rd, rd ? '0 : be, word_at(region, k), data);
            if (region < N_MEMS && !rd && be == '1) begin
                written[region][k] = 1'b1;
            end
        end
    endtask

    initial begin
        seed    = 32'h5e12_c3a5;
        rst     = 1'b1;
        cpu_req = '{default: '0};
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        i_chk.start_test("write_read");
        for (int p = 0; p < N_CPUS; p++) begin
            for (int r = 0; r < N_MEMS; r++) begin
                cpu_access(p, 1'b0, '1, word_at(r, 32 + 4*p), 32'hc0de_0000 | (p << 8) | r);
                cpu_access(p, 1'b1, '0, word_at(r, 32 + 4*p), '0);
            end
        end
        i_chk.end_test();

        // CPU p works in region p.
        i_chk.start_test("byte_enables");
        for (int p = 0; p < N_CPUS; p++) begin
            cpu_access(p, 1'b0, 4'b1111, word_at(p, 64), 32'h1122_3344);
            cpu_access(p, 1'b0, 4'b0001, word_at(p, 64), 32'haaaa_aaaa);
            cpu_access(p, 1'b0, 4'b0110, word_at(p, 64), 32'hbbbb_bbbb);
            cpu_access(p, 1'b0, 4'b1000, word_at(p, 64), 32'hcccc_cccc);
            cpu_access(p, 1'b1, 4'b0000, word_at(p, 64), '0);
        end
        i_chk.end_test();

        // Both CPUs start in the same cycle.
        i_chk.start_test("contention");
        fork
            cpu_access(0, 1'b0, '1, word_at(0, 80), 32'h0bad_f00d);
            cpu_access(1, 1'b0, '1, word_at(1, 80), 32'hfeed_0123);
        join
        fork
            cpu_access(0, 1'b1, '0, word_at(1, 80), '0);
            cpu_access(1, 1'b1, '0, word_at(0, 80), '0);
        join
        i_chk.end_test();

        i_chk.start_test("unmapped");
        for (int p = 0; p < N_CPUS; p++) begin
            cpu_access(p, 1'b0, '1, word_at(N_MEMS, p), 32'hdead_beef);
            cpu_access(p, 1'b1, '0, word_at(N_MEMS, p), '0);
        end
        i_chk.end_test();

        i_chk.start_test("random");
        fork
            random_traffic(0, N_RANDOM / 2);
            random_traffic(1, N_RANDOM / 2);
        join
        i_chk.end_test();

        $display("Checks: %0d, errors: %0d", total_checks, total_errors);
        if (total_errors == 0 && total_checks > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/mem_bus_pkg.sv
logic/mem_arbiter_rr.sv
logic/mem_demux.sv
logic/mem_mux.sv
logic/mem_ram.sv
logic/mem_subsys_top.sv
verif/mem_checker.sv
verif/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  # Design, in compile order.
  - logic/mem_bus_pkg.sv
  - logic/mem_arbiter_rr.sv
  - logic/mem_demux.sv
  - logic/mem_mux.sv
  - logic/mem_ram.sv
  - logic/mem_subsys_top.sv
  # Testbench.
  - target: test
    files:
      - verif/mem_checker.sv
      - verif/tb_mem_subsys.sv
